// File: logic/fpWbPkg.sv
// FP write-back shared definitions
// Active-list and register sizes, pointer types and the lane payload structs

`default_nettype none

package fpWbPkg;

    localparam int AL_ENTRIES = 16;
    localparam int PHY_REGS   = 32;
    localparam int FP_DATA_W  = 64;

    typedef logic [$clog2(AL_ENTRIES)-1:0] alPtrT;
    typedef logic [$clog2(PHY_REGS)-1:0]   phyRegT;

    // {invalid, divide by zero, overflow, underflow, inexact}
    typedef logic [4:0] fflagsT;

    // One result from an FP execution lane
    typedef struct packed {
        logic                 valid;
        alPtrT                alPtr;
        phyRegT               phyReg;
        logic                 writeReg;
        logic                 dataValid;
        logic [FP_DATA_W-1:0] data;
        fflagsT               fflags;
    } fpResultT;

    // Recovery range runs from head up to but not including tail
    typedef struct packed {
        logic  active;
        logic  flushAll;
        alPtrT head;
        alPtrT tail;
    } flushReqT;

    typedef struct packed {
        logic                 we;
        phyRegT               phyReg;
        logic [FP_DATA_W-1:0] data;
    } regWriteT;

    // success low means the instruction must be replayed
    typedef struct packed {
        logic   write;
        alPtrT  alPtr;
        logic   success;
        fflagsT fflags;
    } completionT;

endpackage

`default_nettype wire

// File: logic/fpResultLatch.sv
// FP result latch
// One pipeline register per lane between execution and write-back.
// Loads whenever the back end is not stalled, holds otherwise.

`timescale 1ns/1ns
`default_nettype none

module fpResultLatch #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic             ctrl,
    input  logic             rstN,
    input  logic             stall,
    input  fpWbPkg::fpResultT result  [ISSUE_WIDTH],
    output fpWbPkg::fpResultT latched [ISSUE_WIDTH]
);

    logic [ISSUE_WIDTH-1:0] validVec;

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                latched[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                latched[i] <= result[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            validVec[i] = latched[i].valid;
        end
    end

    // A stray X on a valid would propagate into both sinks
    latchedValidKnown: assert property (
        @(posedge ctrl) disable iff (!rstN)
        !$isunknown(validVec)
    ) else $error("latched valid unknown: %b", validVec);

endmodule

`default_nettype wire

// File: logic/fpWritebackLane.sv
// FP write-back lane
// Checks its instruction against the selective flush range, decides whether
// the result updates state, and forms the register write and completion record.

`timescale 1ns/1ns
`default_nettype none

module fpWritebackLane (
    input  fpWbPkg::fpResultT   entry,
    input  fpWbPkg::flushReqT   flushReq,
    input  logic                stall,
    input  logic                clear,
    output fpWbPkg::regWriteT   regWr,
    output fpWbPkg::completionT cmpl
);

    logic inRange;
    logic flushed;
    logic update;

    always_comb begin
        // head == tail is an empty range; flushAll covers the full one
        if (flushReq.head <= flushReq.tail) begin
            inRange = (entry.alPtr >= flushReq.head) && (entry.alPtr < flushReq.tail);
        end else begin
            // Range wraps past the last active-list entry
            inRange = (entry.alPtr >= flushReq.head) || (entry.alPtr < flushReq.tail);
        end
    end

    assign flushed = flushReq.active && (flushReq.flushAll || inRange);
    assign update  = !stall && !clear && entry.valid && !flushed;

    always_comb begin
        regWr.we     = update && entry.writeReg;
        regWr.phyReg = entry.phyReg;
        regWr.data   = entry.data;
    end

    always_comb begin
        cmpl.write   = update;
        cmpl.alPtr   = entry.alPtr;
        // Data not valid yet, so the op goes back for replay
        cmpl.success = entry.dataValid;
        cmpl.fflags  = entry.fflags;
    end

endmodule

`default_nettype wire

// File: logic/fpRegFile.sv
// FP physical register file
// One write port per lane, higher lane wins on a collision, one async read port

`timescale 1ns/1ns
`default_nettype none

module fpRegFile #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                               ctrl,
    input  logic                               rstN,
    input  fpWbPkg::regWriteT                  regWr [ISSUE_WIDTH],
    input  fpWbPkg::phyRegT                    rdReg,
    output logic [fpWbPkg::FP_DATA_W-1:0]      rdData
);

    logic [fpWbPkg::FP_DATA_W-1:0] regs [fpWbPkg::PHY_REGS];
    logic                          sameRegWrite;

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < fpWbPkg::PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later iterations override, so the highest lane wins
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (regWr[i].we) begin
                    regs[regWr[i].phyReg] <= regWr[i].data;
                end
            end
        end
    end

    assign rdData = regs[rdReg];

    always_comb begin
        sameRegWrite = 1'b0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            for (int j = i + 1; j < ISSUE_WIDTH; j++) begin
                if (regWr[i].we && regWr[j].we && (regWr[i].phyReg == regWr[j].phyReg)) begin
                    sameRegWrite = 1'b1;
                end
            end
        end
    end

    // Rename never maps one physical register to two live ops
    noDualRegWrite: assert property (
        @(posedge ctrl) disable iff (!rstN)
        !sameRegWrite
    ) else $error("two lanes write the same physical register");

endmodule

`default_nettype wire

// File: logic/fpCompletionTable.sv
// FP completion table
// Allocated and done bits per active-list entry plus the sticky
// accumulated exception flags of all successful completions

`timescale 1ns/1ns
`default_nettype none

module fpCompletionTable #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                ctrl,
    input  logic                rstN,
    input  logic                allocValid,
    input  fpWbPkg::alPtrT      allocPtr,
    input  fpWbPkg::completionT cmpl [ISSUE_WIDTH],
    input  fpWbPkg::alPtrT      qPtr,
    output logic                qDone,
    output logic                qAlloc,
    output fpWbPkg::fflagsT     fflagsAcc
);

    logic [fpWbPkg::AL_ENTRIES-1:0] allocated;
    logic [fpWbPkg::AL_ENTRIES-1:0] done;
    fpWbPkg::fflagsT                newFlags;
    logic                           strayWrite;

    always_comb begin
        newFlags   = '0;
        strayWrite = 1'b0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (cmpl[i].write && cmpl[i].success) begin
                newFlags = newFlags | cmpl[i].fflags;
            end
            if (cmpl[i].write && !allocated[cmpl[i].alPtr]) begin
                strayWrite = 1'b1;
            end
        end
    end

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            allocated <= '0;
            done      <= '0;
            fflagsAcc <= '0;
        end else begin
            // Failed completion leaves the entry not done for replay
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (cmpl[i].write) begin
                    done[cmpl[i].alPtr] <= cmpl[i].success;
                end
            end
            // Allocation last so it overrides a same-entry completion
            if (allocValid) begin
                allocated[allocPtr] <= 1'b1;
                done[allocPtr]      <= 1'b0;
            end
            fflagsAcc <= fflagsAcc | newFlags;
        end
    end

    assign qDone  = done[qPtr];
    assign qAlloc = allocated[qPtr];

    // Completion for an entry never handed out by rename
    cmplTargetsAllocated: assert property (
        @(posedge ctrl) disable iff (!rstN)
        !strayWrite
    ) else $error("completion write to an unallocated active-list entry");

endmodule

`default_nettype wire

// File: logic/fpWritebackTop.sv
// FP write-back stage top
// Result latch feeding one write-back lane per issue slot,
// draining into the register file and the completion table

`timescale 1ns/1ns
`default_nettype none

module fpWritebackTop #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                          ctrl,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic                          clear,
    input  fpWbPkg::flushReqT             flushReq,
    input  fpWbPkg::fpResultT             result [ISSUE_WIDTH],
    input  logic                          allocValid,
    input  fpWbPkg::alPtrT                allocPtr,
    input  fpWbPkg::phyRegT               rdReg,
    output logic [fpWbPkg::FP_DATA_W-1:0] rdData,
    input  fpWbPkg::alPtrT                qPtr,
    output logic                          qDone,
    output logic                          qAlloc,
    output fpWbPkg::fflagsT               fflagsAcc
);

    fpWbPkg::fpResultT   latched [ISSUE_WIDTH];
    fpWbPkg::regWriteT   regWr   [ISSUE_WIDTH];
    fpWbPkg::completionT cmpl    [ISSUE_WIDTH];

    fpResultLatch #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) fpResultLatch_i (
        .ctrl    (ctrl),
        .rstN    (rstN),
        .stall   (stall),
        .result  (result),
        .latched (latched)
    );

    // One lane per issue slot
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : genLane
        fpWritebackLane fpWritebackLane_i (
            .entry    (latched[i]),
            .flushReq (flushReq),
            .stall    (stall),
            .clear    (clear),
            .regWr    (regWr[i]),
            .cmpl     (cmpl[i])
        );
    end

    fpRegFile #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) fpRegFile_i (
        .ctrl   (ctrl),
        .rstN   (rstN),
        .regWr  (regWr),
        .rdReg  (rdReg),
        .rdData (rdData)
    );

    fpCompletionTable #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) fpCompletionTable_i (
        .ctrl       (ctrl),
        .rstN       (rstN),
        .allocValid (allocValid),
        .allocPtr   (allocPtr),
        .cmpl       (cmpl),
        .qPtr       (qPtr),
        .qDone      (qDone),
        .qAlloc     (qAlloc),
        .fflagsAcc  (fflagsAcc)
    );

endmodule

`default_nettype wire

// File: verif/fpWritebackTb.sv
// FP write-back stage testbench
// Replays the command file on the DUT and checks registers, done bits and flags

`timescale 1ns/1ns
`default_nettype none

module fpWritebackTb;

    localparam int    ISSUE_WIDTH = 2;
    localparam string CASES_FILE  = "verif/fpWbCases.txt";

    logic                          ctrl = 1'b0;
    logic                          rstN;
    logic                          stall;
    logic                          clear;
    fpWbPkg::flushReqT             flushReq;
    fpWbPkg::fpResultT             result [ISSUE_WIDTH];
    logic                          allocValid;
    fpWbPkg::alPtrT                allocPtr;
    fpWbPkg::phyRegT               rdReg;
    logic [fpWbPkg::FP_DATA_W-1:0] rdData;
    fpWbPkg::alPtrT                qPtr;
    logic                          qDone;
    logic                          qAlloc;
    fpWbPkg::fflagsT               fflagsAcc;

    // Staged by the command file, driven at the next rising edge
    fpWbPkg::fpResultT pendResult [ISSUE_WIDTH];
    fpWbPkg::flushReqT pendFlush;

    // Allocated bits expected from the alloc commands
    logic [fpWbPkg::AL_ENTRIES-1:0] allocModel = '0;

    int    lineCount    = 0;
    logic  linesCounted = 1'b0;
    int    errorCount   = 0;
    int    checkCount   = 0;
    int    testErrors   = 0;
    int    testsPassed  = 0;
    int    testsFailed  = 0;
    string testName     = "";
    logic  lastWasCheck = 1'b0;

    fpWritebackTop #(.ISSUE_WIDTH(ISSUE_WIDTH)) fpWritebackTop_i (.*);

    always #5 ctrl = ~ctrl;

    // One clock cycle with the staged results and flush plus per-cycle strobes
    task automatic advance(input logic stallIn, input logic clearIn,
                           input logic allocIn, input fpWbPkg::alPtrT allocAt);
        @(posedge ctrl);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            result[i] <= pendResult[i];
            pendResult[i].valid = 1'b0;
        end
        flushReq     <= pendFlush;
        stall        <= stallIn;
        clear        <= clearIn;
        allocValid   <= allocIn;
        allocPtr     <= allocAt;
        pendFlush    = '0;
        lastWasCheck = 1'b0;
    endtask

    task automatic reportMismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("Error %s: %s expected %h, actual %h", testName, what, expected, actual);
        testErrors++;
        errorCount++;
    endtask

    // First check after stimulus also waits out the two-edge latency
    task automatic sampleAt(input fpWbPkg::phyRegT regAt, input fpWbPkg::alPtrT ptrAt);
        if (!lastWasCheck) begin
            advance(1'b0, 1'b0, 1'b0, '0);
        end
        advance(1'b0, 1'b0, 1'b0, '0);
        rdReg <= regAt;
        qPtr  <= ptrAt;
        @(negedge ctrl);
        if (qAlloc !== allocModel[ptrAt]) begin
            reportMismatch($sformatf("allocated bit %0d", ptrAt),
                           64'(allocModel[ptrAt]), 64'(qAlloc));
        end
        lastWasCheck = 1'b1;
        checkCount++;
    endtask

    task automatic checkFieldCount(input int got, input int want, input string cmdName);
        if (got != want) begin
            $display("Malformed %s line in test %s", cmdName, testName);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic closeTest();
        if (testName != "") begin
            if (testErrors == 0) begin
                testsPassed++;
                $display("Test %s passed", testName);
            end else begin
                testsFailed++;
                $display("Test %s failed with %0d errors", testName, testErrors);
            end
        end
        testErrors = 0;
    endtask

    // Twenty cycles per command line bound the whole run
    initial begin
        wait (linesCounted);
        repeat (lineCount * 20) @(posedge ctrl);
        $display("Timeout: the cases did not finish within %0d cycles", lineCount * 20);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int                            fd;
        int                            ch;
        int                            code;
        int                            lane;
        string                         cmd;
        logic                          flagA;
        logic                          flagB;
        fpWbPkg::alPtrT                ptr;
        fpWbPkg::alPtrT                tail;
        fpWbPkg::phyRegT               regNum;
        logic [fpWbPkg::FP_DATA_W-1:0] value;
        fpWbPkg::fflagsT               flags;

        rstN       = 1'b0;
        stall      = 1'b0;
        clear      = 1'b0;
        flushReq   = '0;
        allocValid = 1'b0;
        allocPtr   = '0;
        rdReg      = '0;
        qPtr       = '0;
        pendFlush  = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            result[i]     = '0;
            pendResult[i] = '0;
        end

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the cases file %s", CASES_FILE);
            $display(">>> FAIL");
            $finish;
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == 10) begin
                lineCount++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        linesCounted = 1'b1;
        fd = $fopen(CASES_FILE, "r");

        repeat (5) @(posedge ctrl);
        rstN <= 1'b1;

        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": begin
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "test": begin
                    closeTest();
                    code = $fscanf(fd, "%s", testName);
                    checkFieldCount(code, 1, cmd);
                end
                "alloc": begin
                    code = $fscanf(fd, "%d", ptr);
                    checkFieldCount(code, 1, cmd);
                    allocModel[ptr] = 1'b1;
                    advance(1'b0, 1'b0, 1'b1, ptr);
                end
                "result": begin
                    code = $fscanf(fd, "%d %d %d %d %d %h %h",
                                   lane, ptr, regNum, flagA, flagB, value, flags);
                    checkFieldCount(code, 7, cmd);
                    pendResult[lane] = '{valid: 1'b1, alPtr: ptr, phyReg: regNum,
                                         writeReg: flagA, dataValid: flagB,
                                         data: value, fflags: flags};
                end
                "flush": begin
                    code = $fscanf(fd, "%d %d %d", flagA, ptr, tail);
                    checkFieldCount(code, 3, cmd);
                    pendFlush = '{active: 1'b1, flushAll: flagA, head: ptr, tail: tail};
                end
                "stall": advance(1'b1, 1'b0, 1'b0, '0);
                "clear": advance(1'b0, 1'b1, 1'b0, '0);
                "idle":  advance(1'b0, 1'b0, 1'b0, '0);
                "reg": begin
                    code = $fscanf(fd, "%d %h", regNum, value);
                    checkFieldCount(code, 2, cmd);
                    sampleAt(regNum, '0);
                    if (rdData !== value) begin
                        reportMismatch($sformatf("register %0d", regNum), value, rdData);
                    end
                end
                "done": begin
                    code = $fscanf(fd, "%d %d", ptr, flagA);
                    checkFieldCount(code, 2, cmd);
                    sampleAt('0, ptr);
                    if (qDone !== flagA) begin
                        reportMismatch($sformatf("done bit %0d", ptr), 64'(flagA), 64'(qDone));
                    end
                end
                "flags": begin
                    code = $fscanf(fd, "%h", flags);
                    checkFieldCount(code, 1, cmd);
                    sampleAt('0, '0);
                    if (fflagsAcc !== flags) begin
                        reportMismatch("fflagsAcc", 64'(flags), 64'(fflagsAcc));
                    end
                end
                default: begin
                    $display("Unknown command %s in test %s", cmd, testName);
                    testErrors++;
                    errorCount++;
                end
            endcase
        end
        $fclose(fd);
        closeTest();

        $display("Tests %0d passed, %0d failed, checks %0d, errors %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/fpWbPkg.sv
logic/fpResultLatch.sv
logic/fpWritebackLane.sv
logic/fpRegFile.sv
logic/fpCompletionTable.sv
logic/fpWritebackTop.sv
verif/fpWritebackTb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = fpWritebackTb
LIST  = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/fpWbCases.txt
# test name | alloc ptr | result lane ptr reg writeReg dataValid data flags | flush all head tail
# stall | clear | idle | reg r value | done ptr value | flags value  (data, value, flags in hex)
test basicWrite
alloc 1
alloc 2
result 0 1 3 1 1 3ff0000000000000 00
result 1 2 4 1 1 4000000000000000 01
idle
reg 3 3ff0000000000000
reg 4 4000000000000000
done 1 1
done 2 1
flags 01
test replayNoWrite
alloc 3
alloc 4
result 0 3 5 1 0 1111 10
result 1 4 4 0 1 2222 02
idle
reg 5 1111
reg 4 4000000000000000
done 3 0
done 4 1
flags 03
test flushWrap
alloc 2
result 0 14 6 1 1 aaaa 04
result 1 2 7 1 1 bbbb 08
idle
flush 0 14 2
result 0 15 8 1 1 cccc 04
result 1 0 9 1 1 cccc 04
idle
flush 0 14 2
result 0 1 10 1 1 cccc 04
idle
flush 0 14 2
result 0 3 11 1 1 dddd 10
result 1 2 12 1 1 dddd 10
idle
flush 1 0 0
idle
reg 6 0
reg 7 bbbb
reg 8 0
reg 10 0
reg 12 0
done 2 1
done 3 0
test stallClear
alloc 5
result 0 5 13 1 1 1234 01
idle
stall
stall
reg 13 1234
result 1 6 14 1 1 5678 10
idle
clear
reg 14 0
flags 0b
test stickyRealloc
alloc 7
result 0 7 15 1 1 9999 14
idle
done 7 1
flags 1f
alloc 7
done 7 0
